/* filelist.f */
+incdir+verilog
verilog/wbuf_pkg.sv
verilog/write_combine_buffer.sv
verilog/byte_lane_memory.sv
verilog/read_merge.sv
verilog/write_buffer_top.sv
test/write_buffer_tb.sv

/* test/write_buffer_vectors.txt */
# columns: op name addr data strb exp, numbers in hex
# op w write, f forward, r read, h hold level in data, i idle
# exp is first-cycle ready for w and f, read data for r
r z0 00 00000000 0 00000000
r z1 ff 00000000 0 00000000
r z2 5a 00000000 0 00000000
w b1w0 10 11223344 f 1
w b1w1 20 a5a5a5a5 3 1
i idle0 00 00000000 0 0
r b1r0 10 00000000 0 11223344
r b1r1 20 00000000 0 0000a5a5
h hold1 00 00000001 0 0
w b2w0 30 11111111 1 1
w b2w1 30 22222222 4 1
w b2w2 30 33333333 6 1
r b5r0 30 00000000 0 00333311
r b5r1 10 00000000 0 11223344
f b4f0 30 aa000000 8 1
f b4f1 30 0000bb00 2 1
f b4f2 40 cccccccc f 0
h hold0 00 00000000 0 0
r b2r0 30 00000000 0 aa33bb11
r b4r0 40 00000000 0 00000000
f b4f3 30 dddddddd f 0
r b4r1 30 00000000 0 aa33bb11
h hold2 00 00000001 0 0
w b3w0 50 12345678 f 1
w b3w1 60 9abcdef0 f 0
r b3r0 60 00000000 0 9abcdef0
r b3r1 50 00000000 0 12345678
r b3r2 60 00000000 0 9abcdef0
h hold3 00 00000001 0 0
w b5w0 10 0000ee00 2 1
r b5r2 10 00000000 0 1122ee44
r b5r3 20 00000000 0 0000a5a5
f b4f4 10 000000ff 1 1
r b5r4 10 00000000 0 1122eeff
h hold4 00 00000000 0 0
i idle1 00 00000000 0 0
r b1r2 10 00000000 0 1122eeff
w b1w2 ff deadbeef 9 1
i idle2 00 00000000 0 0
r b1r3 ff 00000000 0 de0000ef
w b2w3 ff 00c0ffee 6 1
w b2w4 ff 11111111 1 1
r b2r1 ff 00000000 0 dec0ff11
i idle3 00 00000000 0 0
r b2r2 ff 00000000 0 dec0ff11
r z3 80 00000000 0 00000000
r z4 81 00000000 0 00000000

/* test/write_buffer_tb.sv */
// ----------------------------------------------------------
// replays test/write_buffer_vectors.txt, run from project root
// a blocked write drops mem_hold before it retries
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module write_buffer_tb;

    import wbuf_pkg::*;

    localparam int PERIOD = 40;

    logic                        clk;
    logic                        reset;
    wr_req_t                     wr_req;
    logic                        wr_valid;
    logic                        wr_ready;
    wr_req_t                     fwd_req;
    logic                        fwd_valid;
    logic                        fwd_ready;
    logic                        mem_hold;
    logic                        rd_req;
    logic [`WBUF_ADDR_WIDTH-1:0] rd_addr;
    rd_resp_t                    rd_resp;
    logic                        rd_valid;

    // vectors, one entry per file line
    string                       ops[$];
    string                       names[$];
    logic [`WBUF_ADDR_WIDTH-1:0] vec_addr[$];
    logic [`WBUF_DATA_WIDTH-1:0] vec_data[$];
    logic [`WBUF_STRB_WIDTH-1:0] vec_strb[$];
    logic [`WBUF_DATA_WIDTH-1:0] vec_exp[$];
    int                          num_vec;
    int                          num_checks;
    logic                        loaded;
    string                       cur_name;

    // read in flight
    logic                        rd_pending;
    string                       pend_name;
    rd_resp_t                    pend_exp;

    // reference model state
    logic [`WBUF_DATA_WIDTH-1:0] model_mem [`WBUF_MEM_WORDS];
    wr_req_t                     model_entry;
    logic                        model_valid;
    logic [`WBUF_DATA_WIDTH-1:0] model_rd;
    logic                        model_on;

    write_buffer_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // ----------------------------------------------------------
    // error handling and compares
    // ----------------------------------------------------------
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        num_checks++;
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch %s: expected %0b, actual %0b", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input rd_resp_t exp, input rd_resp_t act);
        num_checks++;
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input logic [`WBUF_DATA_WIDTH-1:0] exp,
                              input logic [`WBUF_DATA_WIDTH-1:0] act);
        num_checks++;
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // ----------------------------------------------------------
    // reference model, one step per rising edge
    // ----------------------------------------------------------
    function automatic logic [`WBUF_DATA_WIDTH-1:0] lay_bytes(
        input logic [`WBUF_DATA_WIDTH-1:0] base,
        input logic [`WBUF_DATA_WIDTH-1:0] over,
        input logic [`WBUF_STRB_WIDTH-1:0] strb
    );
        logic [`WBUF_DATA_WIDTH-1:0] word;
        word = base;
        for (int i = 0; i < `WBUF_STRB_WIDTH; i++) begin
            if (strb[i]) begin
                word[i*8 +: 8] = over[i*8 +: 8];
            end
        end
        return word;
    endfunction

    // a drain in this cycle frees the entry
    function automatic logic host_ready(input wr_req_t req);
        return !model_valid || !mem_hold || (req.addr == model_entry.addr);
    endfunction

    task automatic model_step();
        logic take;
        logic hit;
        take = wr_valid && host_ready(wr_req);
        hit  = model_valid && (model_entry.addr == rd_addr);
        // read sees memory and entry from before the edge
        if (rd_req) begin
            model_rd = lay_bytes(model_mem[rd_addr], model_entry.data,
                                 hit ? model_entry.strb : '0);
        end
        if (model_valid && !mem_hold) begin
            model_mem[model_entry.addr] = lay_bytes(model_mem[model_entry.addr],
                                                    model_entry.data, model_entry.strb);
            model_valid      = 1'b0;
            model_entry.strb = '0;
        end
        if (take) begin
            model_entry.addr = wr_req.addr;
            model_entry.data = lay_bytes(model_entry.data, wr_req.data, wr_req.strb);
            model_entry.strb = model_entry.strb | wr_req.strb;
            model_valid      = model_valid || (|wr_req.strb);
        end
        // forwarding bytes land last
        if (fwd_valid && model_valid && (fwd_req.addr == model_entry.addr)) begin
            model_entry.data = lay_bytes(model_entry.data, fwd_req.data, fwd_req.strb);
            model_entry.strb = model_entry.strb | fwd_req.strb;
        end
    endtask

    always @(posedge clk) begin
        if (model_on) begin
            model_step();
        end
    end

    // ----------------------------------------------------------
    // vector loading and replay
    // ----------------------------------------------------------
    task automatic load_vectors();
        int                          fd;
        int                          n;
        string                       line;
        string                       op;
        string                       name;
        logic [`WBUF_ADDR_WIDTH-1:0] a;
        logic [`WBUF_DATA_WIDTH-1:0] d;
        logic [`WBUF_STRB_WIDTH-1:0] s;
        logic [`WBUF_DATA_WIDTH-1:0] e;
        fd = $fopen("test/write_buffer_vectors.txt", "r");
        if (fd == 0) begin
            stop_on_error("cannot open test/write_buffer_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h %h", op, name, a, d, s, e);
                    if (n == 6) begin
                        ops.push_back(op);
                        names.push_back(name);
                        vec_addr.push_back(a);
                        vec_data.push_back(d);
                        vec_strb.push_back(s);
                        vec_exp.push_back(e);
                    end
                end
            end
            $fclose(fd);
            num_vec = ops.size();
            loaded  = 1'b1;
        end
    endtask

    // falling edge, collect last cycle's read, idle the inputs
    task automatic next_cycle();
        @(negedge clk);
        check_ready({cur_name, " rd_valid"}, rd_pending, rd_valid);
        if (rd_pending) begin
            check_resp(pend_name, pend_exp, rd_resp);
            check_data({pend_name, " model"}, pend_exp.data, model_rd);
        end
        rd_pending = 1'b0;
        wr_valid   = 1'b0;
        fwd_valid  = 1'b0;
        rd_req     = 1'b0;
    endtask

    task automatic run_vector(input int i);
        next_cycle();
        cur_name = names[i];
        if (ops[i] == "w") begin
            wr_req   = {vec_addr[i], vec_data[i], vec_strb[i]};
            wr_valid = 1'b1;
            #(PERIOD/4);
            check_ready(names[i], vec_exp[i][0], wr_ready);
            // stalled behind another address, let the drain go
            while (!wr_ready) begin
                next_cycle();
                mem_hold = 1'b0;
                wr_valid = 1'b1;
                #(PERIOD/4);
            end
        end else if (ops[i] == "f") begin
            fwd_req   = {vec_addr[i], vec_data[i], vec_strb[i]};
            fwd_valid = 1'b1;
            #(PERIOD/4);
            check_ready(names[i], vec_exp[i][0], fwd_ready);
        end else if (ops[i] == "r") begin
            rd_req     = 1'b1;
            rd_addr    = vec_addr[i];
            rd_pending = 1'b1;
            pend_name  = names[i];
            pend_exp   = {vec_addr[i], vec_exp[i]};
        end else if (ops[i] == "h") begin
            mem_hold = vec_data[i][0];
        end else if (ops[i] != "i") begin
            stop_on_error({"unknown operation ", ops[i], " in vector file"});
        end
    endtask

    initial begin
        reset       = 1'b1;
        wr_req      = '0;
        wr_valid    = 1'b0;
        fwd_req     = '0;
        fwd_valid   = 1'b0;
        mem_hold    = 1'b0;
        rd_req      = 1'b0;
        rd_addr     = '0;
        rd_pending  = 1'b0;
        loaded      = 1'b0;
        model_on    = 1'b0;
        model_valid = 1'b0;
        model_entry = '0;
        model_rd    = '0;
        num_checks  = 0;
        cur_name    = "reset";
        for (int i = 0; i < `WBUF_MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        load_vectors();
        repeat (4) @(negedge clk);
        reset = 1'b0;
        // memory zero-fill takes one cycle per word
        repeat (`WBUF_MEM_WORDS + 4) @(negedge clk);
        model_on = 1'b1;
        for (int i = 0; i < num_vec; i++) begin
            run_vector(i);
        end
        next_cycle();
        if (num_checks > 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_on_error("no checks were made, vector file is empty");
        end
    end

    // watchdog sized from vector count and clear time
    initial begin
        wait (loaded === 1'b1);
        repeat (num_vec * 20 + `WBUF_MEM_WORDS + 8) @(posedge clk);
        stop_on_error("watchdog expired before all vectors were replayed");
    end

endmodule

/* verilog/write_buffer_top.sv */
// ----------------------------------------------------------
// write buffer in front of a byte-lane memory, writes stall
// for WBUF_MEM_WORDS cycles after reset while memory clears
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module write_buffer_top (
    input  logic                        clk,
    input  logic                        reset,

    // host and forwarding writes
    input  wbuf_pkg::wr_req_t           wr_req,
    input  logic                        wr_valid,
    output logic                        wr_ready,
    input  wbuf_pkg::wr_req_t           fwd_req,
    input  logic                        fwd_valid,
    output logic                        fwd_ready,

    // drain stall
    input  logic                        mem_hold,

    // read port
    input  logic                        rd_req,
    input  logic [`WBUF_ADDR_WIDTH-1:0] rd_addr,
    output wbuf_pkg::rd_resp_t          rd_resp,
    output logic                        rd_valid
);

    import wbuf_pkg::*;

    wr_req_t                     drain_req;
    logic                        drain_valid;
    logic                        drain_ready;
    wr_req_t                     pend;
    logic                        pend_valid;
    logic [`WBUF_DATA_WIDTH-1:0] rd_word;

    write_combine_buffer u_buffer (
        .clk        (clk),
        .reset      (reset),
        .wr_req     (wr_req),
        .wr_valid   (wr_valid),
        .wr_ready   (wr_ready),
        .fwd_req    (fwd_req),
        .fwd_valid  (fwd_valid),
        .fwd_ready  (fwd_ready),
        .drain_req  (drain_req),
        .drain_valid(drain_valid),
        .drain_ready(drain_ready),
        .pend       (pend),
        .pend_valid (pend_valid)
    );

    byte_lane_memory u_memory (
        .clk        (clk),
        .reset      (reset),
        .drain_req  (drain_req),
        .drain_valid(drain_valid),
        .drain_ready(drain_ready),
        .mem_hold   (mem_hold),
        .rd_addr    (rd_addr),
        .rd_word    (rd_word)
    );

    // memory and overlay both see the same request address
    read_merge u_read (
        .clk        (clk),
        .reset      (reset),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .pend       (pend),
        .pend_valid (pend_valid),
        .rd_word    (rd_word),
        .rd_resp    (rd_resp),
        .rd_valid   (rd_valid)
    );

endmodule

/* verilog/read_merge.sv */
// ----------------------------------------------------------
// one-cycle read with no back-pressure
// pending bytes from the request edge lay over the memory word
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module read_merge (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        rd_req,
    input  logic [`WBUF_ADDR_WIDTH-1:0] rd_addr,
    input  wbuf_pkg::wr_req_t           pend,
    input  logic                        pend_valid,
    input  logic [`WBUF_DATA_WIDTH-1:0] rd_word,
    output wbuf_pkg::rd_resp_t          rd_resp,
    output logic                        rd_valid
);

    logic [`WBUF_ADDR_WIDTH-1:0] addr_q;
    logic [`WBUF_DATA_WIDTH-1:0] ovl_data_q;
    logic [`WBUF_STRB_WIDTH-1:0] ovl_strb_q;
    logic                        valid_q;
    logic                        hit;

    // pending entry only counts for its own address
    assign hit = pend_valid && (pend.addr == rd_addr);

    // ----------------------------------------------------------
    // request stage
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q    <= 1'b0;
            ovl_strb_q <= '0;
        end else begin
            valid_q <= rd_req;
            if (rd_req) begin
                ovl_strb_q <= hit ? pend.strb : '0;
            end
        end
    end

    // request address and overlay bytes
    always_ff @(posedge clk) begin
        if (rd_req) begin
            addr_q     <= rd_addr;
            ovl_data_q <= pend.data;
        end
    end

    // ----------------------------------------------------------
    // response stage with byte-wise overlay
    // ----------------------------------------------------------
    always_comb begin
        rd_resp.addr = addr_q;
        for (int i = 0; i < `WBUF_STRB_WIDTH; i++) begin
            rd_resp.data[i*8 +: 8] = ovl_strb_q[i] ? ovl_data_q[i*8 +: 8]
                                                   : rd_word[i*8 +: 8];
        end
    end

    assign rd_valid = valid_q;

endmodule

/* verilog/byte_lane_memory.sv */
// ----------------------------------------------------------
// word memory with byte-strobed writes, zero-filled after
// reset over WBUF_MEM_WORDS cycles with drains held off
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module byte_lane_memory (
    input  logic                        clk,
    input  logic                        reset,
    input  wbuf_pkg::wr_req_t           drain_req,
    input  logic                        drain_valid,
    output logic                        drain_ready,
    input  logic                        mem_hold,
    input  logic [`WBUF_ADDR_WIDTH-1:0] rd_addr,
    output logic [`WBUF_DATA_WIDTH-1:0] rd_word
);

    logic [`WBUF_DATA_WIDTH-1:0] mem [`WBUF_MEM_WORDS];
    logic [`WBUF_ADDR_WIDTH-1:0] clr_cnt;
    logic                        clearing;

    // ----------------------------------------------------------
    // clearing sequence, one word per cycle
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            clearing <= 1'b1;
            clr_cnt  <= '0;
        end else if (clearing) begin
            clr_cnt <= clr_cnt + 1'b1;
            if (clr_cnt == `WBUF_ADDR_WIDTH'(`WBUF_MEM_WORDS - 1)) begin
                clearing <= 1'b0;
            end
        end
    end

    assign drain_ready = !mem_hold && !clearing;

    // write port, only strobed lanes change
    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clr_cnt] <= '0;
        end else if (drain_valid && drain_ready) begin
            for (int i = 0; i < `WBUF_STRB_WIDTH; i++) begin
                if (drain_req.strb[i]) begin
                    mem[drain_req.addr][i*8 +: 8] <= drain_req.data[i*8 +: 8];
                end
            end
        end
    end

    // read returns the word as it was before this edge
    always_ff @(posedge clk) begin
        rd_word <= mem[rd_addr];
    end

endmodule

/* verilog/write_combine_buffer.sv */
// ----------------------------------------------------------
// one-entry merging write buffer, forwarding never opens
// an empty entry and wins over host bytes on the same lane
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module write_combine_buffer (
    input  logic             clk,
    input  logic             reset,

    // host write
    input  wbuf_pkg::wr_req_t wr_req,
    input  logic             wr_valid,
    output logic             wr_ready,

    // forwarding overwrite
    input  wbuf_pkg::wr_req_t fwd_req,
    input  logic             fwd_valid,
    output logic             fwd_ready,

    // drain towards memory
    output wbuf_pkg::wr_req_t drain_req,
    output logic             drain_valid,
    input  logic             drain_ready,

    // snapshot for the read path
    output wbuf_pkg::wr_req_t pend,
    output logic             pend_valid
);

    import wbuf_pkg::*;

    wr_req_t entry_q;
    wr_req_t entry_d;
    logic    valid_q;
    logic    valid_d;

    // ----------------------------------------------------------
    // next state: drain, then host merge, then forwarding
    // ----------------------------------------------------------
    always_comb begin
        entry_d   = entry_q;
        valid_d   = valid_q;
        wr_ready  = 1'b0;
        fwd_ready = 1'b0;

        // drained entry is free again this cycle
        if (drain_valid && drain_ready) begin
            entry_d.strb = '0;
            valid_d      = 1'b0;
        end

        // host bytes merge into an empty or matching entry
        if (!valid_d || (wr_req.addr == entry_d.addr)) begin
            wr_ready = 1'b1;
            if (wr_valid) begin
                entry_d.addr = wr_req.addr;
                for (int i = 0; i < `WBUF_STRB_WIDTH; i++) begin
                    if (wr_req.strb[i]) begin
                        entry_d.data[i*8 +: 8] = wr_req.data[i*8 +: 8];
                        entry_d.strb[i]        = 1'b1;
                        valid_d                = 1'b1;
                    end
                end
            end
        end

        // forwarding only touches a live entry at its address
        if (valid_d && (fwd_req.addr == entry_d.addr)) begin
            fwd_ready = 1'b1;
            if (fwd_valid) begin
                for (int i = 0; i < `WBUF_STRB_WIDTH; i++) begin
                    if (fwd_req.strb[i]) begin
                        entry_d.data[i*8 +: 8] = fwd_req.data[i*8 +: 8];
                        entry_d.strb[i]        = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            entry_q.strb <= '0;
            valid_q      <= 1'b0;
        end else begin
            entry_q <= entry_d;
            valid_q <= valid_d;
        end
    end

    // entry goes out as is, strobes cover every gathered byte
    assign drain_req   = entry_q;
    assign drain_valid = valid_q;
    assign pend        = entry_q;
    assign pend_valid  = valid_q;

endmodule

/* verilog/wbuf_pkg.sv */
// ----------------------------------------------------------
// request and response types for the write buffer path
// ----------------------------------------------------------
`include "wbuf_defs.svh"

package wbuf_pkg;

    // ----------------------------------------------------------
    // write request, also used for drain and pending snapshot
    // ----------------------------------------------------------
    typedef struct packed {
        logic [`WBUF_ADDR_WIDTH-1:0] addr;
        logic [`WBUF_DATA_WIDTH-1:0] data;
        // one bit per byte lane
        logic [`WBUF_STRB_WIDTH-1:0] strb;
    } wr_req_t;

    // ----------------------------------------------------------
    // read result with pending bytes already merged in
    // ----------------------------------------------------------
    typedef struct packed {
        logic [`WBUF_ADDR_WIDTH-1:0] addr;
        logic [`WBUF_DATA_WIDTH-1:0] data;
    } rd_resp_t;

endpackage

/* verilog/wbuf_defs.svh */
// ----------------------------------------------------------
// sizes shared by the write buffer, memory and read path
// memory depth always follows the address width
// ----------------------------------------------------------
`ifndef WBUF_DEFS_SVH
`define WBUF_DEFS_SVH

// word address and data geometry
`define WBUF_ADDR_WIDTH 8
`define WBUF_DATA_SIZE  2
`define WBUF_DATA_WIDTH (8 << `WBUF_DATA_SIZE)
`define WBUF_STRB_WIDTH (1 << `WBUF_DATA_SIZE)

// one word per address
`define WBUF_MEM_WORDS  (1 << `WBUF_ADDR_WIDTH)

`endif
